/* logic/fpPkg.sv */
// Binary32 adder package with the word layout, field widths and special-value constants
package fpPkg;

    localparam int expWidth = 8;
    localparam int manWidth = 23;

    // Implicit one plus stored mantissa
    localparam int alignWidth = manWidth + 1;

    // Carry, aligned mantissa, guard and round
    localparam int sumWidth = alignWidth + 3;

    localparam logic [expWidth-1:0] expMax = '1;    // Infinity or NaN
    localparam logic [31:0] quietNan = 32'h7FC0_0000;

    typedef struct packed
    {
        logic sign;
        logic [expWidth-1:0] exponent;
        logic [manWidth-1:0] mantissa;
    } fpFields_t;

    // Same 32 bits seen either as a raw word or as IEEE-754 fields
    typedef union packed
    {
        logic [31:0] bits;
        fpFields_t fields;
    } fpWord_t;

endpackage

/* logic/fpAlign.sv */
`timescale 1ns/100ps
// Alignment stage that compares exponents, shifts the smaller mantissa and flags inf/NaN inputs
module fpAlign
(
    input  fpPkg::fpWord_t operandA,
    input  fpPkg::fpWord_t operandB,
    output logic [fpPkg::alignWidth-1:0] alignedMantissaA,
    output logic [fpPkg::alignWidth-1:0] alignedMantissaB,
    output logic [fpPkg::expWidth-1:0] exponentOut,
    output logic guardBit,
    output logic roundBit,
    output logic stickyBit,
    output logic special,
    output fpPkg::fpWord_t specialWord
);
    import fpPkg::*;

    localparam int extWidth = alignWidth + 2;      // Room for guard and round below the lsb

    logic [expWidth-1:0] exponentDifferential;
    logic [extWidth-1:0] extendedMantissaA;
    logic [extWidth-1:0] extendedMantissaB;
    logic [extWidth-1:0] largerMantissa;
    logic [extWidth-1:0] smallerMantissa;
    logic [2*extWidth-1:0] shiftedMantissa;
    logic [alignWidth-1:0] smallerAligned;
    logic aIsLarger;
    logic nanA, nanB, infA, infB;

    // Zero exponent field flushes the operand, so subnormals act as zero
    assign extendedMantissaA = (operandA.fields.exponent == '0) ? '0 :
                               {1'b1, operandA.fields.mantissa, 2'b00};
    assign extendedMantissaB = (operandB.fields.exponent == '0) ? '0 :
                               {1'b1, operandB.fields.mantissa, 2'b00};

    assign aIsLarger = operandA.fields.exponent >= operandB.fields.exponent;

    always_comb
    begin
        if (aIsLarger)
        begin
            exponentDifferential = operandA.fields.exponent - operandB.fields.exponent;
            exponentOut = operandA.fields.exponent;
            largerMantissa = extendedMantissaA;
            smallerMantissa = extendedMantissaB;
        end
        else
        begin
            exponentDifferential = operandB.fields.exponent - operandA.fields.exponent;
            exponentOut = operandB.fields.exponent;
            largerMantissa = extendedMantissaB;
            smallerMantissa = extendedMantissaA;
        end

        // Lower half catches every bit that falls off the end
        shiftedMantissa = {smallerMantissa, {extWidth{1'b0}}} >> exponentDifferential;

        if (exponentDifferential > extWidth)
        begin
            {smallerAligned, guardBit, roundBit} = '0;
            stickyBit = |smallerMantissa;                 // Whole operand is below round
        end
        else
        begin
            {smallerAligned, guardBit, roundBit} = shiftedMantissa[2*extWidth-1 -: extWidth];
            stickyBit = |shiftedMantissa[extWidth-1:0];
        end
    end

    assign alignedMantissaA = aIsLarger ? largerMantissa[extWidth-1:2] : smallerAligned;
    assign alignedMantissaB = aIsLarger ? smallerAligned : largerMantissa[extWidth-1:2];

    // Classification of all-ones exponents
    assign nanA = (operandA.fields.exponent == expMax) && (operandA.fields.mantissa != '0);
    assign nanB = (operandB.fields.exponent == expMax) && (operandB.fields.mantissa != '0);
    assign infA = (operandA.fields.exponent == expMax) && (operandA.fields.mantissa == '0);
    assign infB = (operandB.fields.exponent == expMax) && (operandB.fields.mantissa == '0);

    assign special = nanA | nanB | infA | infB;

    always_comb
    begin
        if (nanA || nanB || (infA && infB && (operandA.fields.sign != operandB.fields.sign)))
            specialWord.bits = quietNan;                  // Invalid sum
        else if (infA)
            specialWord = operandA;
        else
            specialWord = operandB;
    end

endmodule

/* logic/fpMantissaAdd.sv */
`timescale 1ns/100ps
// Signed-magnitude mantissa adder working on the aligned values and their rounding bits
module fpMantissaAdd
(
    input  logic signA,
    input  logic signB,
    input  logic [fpPkg::alignWidth-1:0] alignedMantissaA,
    input  logic [fpPkg::alignWidth-1:0] alignedMantissaB,
    input  logic guardBit,
    input  logic roundBit,
    input  logic stickyBit,
    output logic [fpPkg::sumWidth-1:0] rawSum,
    output logic sumSign,
    output logic sumSticky
);
    import fpPkg::*;

    localparam int magWidth = alignWidth + 2;

    logic ownsRoundBitsA;
    logic aIsLarger;
    logic [magWidth-1:0] magnitudeA;
    logic [magWidth-1:0] magnitudeB;
    logic [magWidth-1:0] largerMagnitude;
    logic [magWidth-1:0] smallerMagnitude;
    logic [magWidth:0] difference;

    // The shifted operand lost its implicit one, so it is the smaller aligned value
    assign ownsRoundBitsA = alignedMantissaA < alignedMantissaB;

    assign magnitudeA = {alignedMantissaA, ownsRoundBitsA ? {guardBit, roundBit} : 2'b00};
    assign magnitudeB = {alignedMantissaB, ownsRoundBitsA ? 2'b00 : {guardBit, roundBit}};

    assign aIsLarger = magnitudeA >= magnitudeB;
    assign largerMagnitude = aIsLarger ? magnitudeA : magnitudeB;
    assign smallerMagnitude = aIsLarger ? magnitudeB : magnitudeA;

    // Sticky borrows one place below round
    assign difference = {largerMagnitude, 1'b0} - {smallerMagnitude, stickyBit};

    always_comb
    begin
        if (signA == signB)
        begin
            rawSum = {1'b0, magnitudeA} + {1'b0, magnitudeB};
            sumSticky = stickyBit;
            sumSign = signA;
        end
        else
        begin
            rawSum = {1'b0, difference[magWidth:1]};      // Never carries
            sumSticky = difference[0];
            if (magnitudeA == magnitudeB)
                sumSign = 1'b0;                           // Exact cancellation gives +0
            else
                sumSign = aIsLarger ? signA : signB;
        end
    end

endmodule

/* logic/fpNormalize.sv */
`timescale 1ns/100ps
// Normalizer that realigns the raw sum to a leading one and adjusts the exponent
module fpNormalize
(
    input  logic [fpPkg::sumWidth-1:0] rawSum,
    input  logic sumSticky,
    input  logic [fpPkg::expWidth-1:0] exponentIn,
    output logic [fpPkg::alignWidth-1:0] normMantissa,
    output logic [fpPkg::expWidth:0] normExponent,
    output logic guardBit,
    output logic roundBit,
    output logic stickyBit,
    output logic isZero
);
    import fpPkg::*;

    logic [4:0] leadingZeros;
    logic [sumWidth-2:0] shiftedSum;

    // Priority search below the carry bit, highest set bit wins
    always_comb
    begin
        leadingZeros = 5'(sumWidth - 1);
        for (int i = 0; i < sumWidth - 1; i++)
        begin
            if (rawSum[i])
                leadingZeros = 5'(sumWidth - 2 - i);
        end
    end

    assign shiftedSum = rawSum[sumWidth-2:0] << leadingZeros;
    assign isZero = (rawSum == '0);

    always_comb
    begin
        if (rawSum[sumWidth-1])
        begin
            // Carry out, so shift right by one
            normMantissa = rawSum[sumWidth-1 -: alignWidth];
            guardBit = rawSum[2];
            roundBit = rawSum[1];
            stickyBit = rawSum[0] | sumSticky;            // Old round bit drops into sticky
            normExponent = {1'b0, exponentIn} + 1'b1;
        end
        else
        begin
            normMantissa = shiftedSum[sumWidth-2 -: alignWidth];
            guardBit = shiftedSum[1];
            roundBit = shiftedSum[0];
            stickyBit = sumSticky;
            // Goes negative on underflow, seen as signed downstream
            normExponent = {1'b0, exponentIn} - {4'b0000, leadingZeros};
        end
    end

endmodule

/* logic/fpRound.sv */
`timescale 1ns/100ps
// Round-to-nearest-even stage with overflow and underflow handling and final word packing
module fpRound
(
    input  logic sign,
    input  logic [fpPkg::alignWidth-1:0] normMantissa,
    input  logic [fpPkg::expWidth:0] normExponent,
    input  logic guardBit,
    input  logic roundBit,
    input  logic stickyBit,
    input  logic isZero,
    input  logic special,
    input  fpPkg::fpWord_t specialWord,
    output fpPkg::fpWord_t roundedWord
);
    import fpPkg::*;

    logic roundUp;
    logic [alignWidth:0] roundedMantissa;
    logic signed [expWidth+1:0] finalExponent;
    logic [manWidth-1:0] finalFraction;

    // Ties go to the even mantissa
    assign roundUp = guardBit & (roundBit | stickyBit | normMantissa[0]);
    assign roundedMantissa = {1'b0, normMantissa} + {{alignWidth{1'b0}}, roundUp};

    // A mantissa carry leaves 1.000..., only the exponent moves
    assign finalExponent = $signed({normExponent[expWidth], normExponent})
                         + $signed({{(expWidth+1){1'b0}}, roundedMantissa[alignWidth]});
    assign finalFraction = roundedMantissa[alignWidth] ? roundedMantissa[manWidth:1]
                                                       : roundedMantissa[manWidth-1:0];

    always_comb
    begin
        roundedWord.fields.sign = sign;
        roundedWord.fields.exponent = finalExponent[expWidth-1:0];
        roundedWord.fields.mantissa = finalFraction;

        if (special)
            roundedWord = specialWord;                    // Inf or NaN from alignment
        else if (isZero || (finalExponent <= 0))
        begin
            roundedWord.fields.exponent = '0;             // Flush to signed zero
            roundedWord.fields.mantissa = '0;
        end
        else if (finalExponent >= $signed({2'b00, expMax}))
        begin
            roundedWord.fields.exponent = expMax;         // Overflow to infinity
            roundedWord.fields.mantissa = '0;
        end
    end

endmodule

/* logic/fpAdder.sv */
`timescale 1ns/100ps
// Two-stage pipelined binary32 adder with valid strobes
module fpAdder
(
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  fpPkg::fpWord_t operandA,
    input  fpPkg::fpWord_t operandB,
    output logic outValid,
    output fpPkg::fpWord_t result
);
    import fpPkg::*;

    // Stage 1 combinational results
    logic [alignWidth-1:0] alignedMantissaA;
    logic [alignWidth-1:0] alignedMantissaB;
    logic [expWidth-1:0] alignExponent;
    logic alignGuard, alignRound, alignSticky;
    logic alignSpecial;
    fpWord_t alignSpecialWord;
    logic [sumWidth-1:0] rawSum;
    logic sumSign;
    logic sumSticky;

    // Stage 1 register
    logic s1Valid;
    logic [expWidth-1:0] s1Exponent;
    logic [sumWidth-1:0] s1RawSum;
    logic s1Sign, s1Sticky, s1Special;
    fpWord_t s1SpecialWord;

    // Stage 2 combinational results
    logic [alignWidth-1:0] normMantissa;
    logic [expWidth:0] normExponent;
    logic normGuard, normRound, normSticky;
    logic sumIsZero;
    fpWord_t roundedWord;

    fpAlign i_align
    (
        .operandA         (operandA),
        .operandB         (operandB),
        .alignedMantissaA (alignedMantissaA),
        .alignedMantissaB (alignedMantissaB),
        .exponentOut      (alignExponent),
        .guardBit         (alignGuard),
        .roundBit         (alignRound),
        .stickyBit        (alignSticky),
        .special          (alignSpecial),
        .specialWord      (alignSpecialWord)
    );

    fpMantissaAdd i_mantissaAdd
    (
        .signA            (operandA.fields.sign),
        .signB            (operandB.fields.sign),
        .alignedMantissaA (alignedMantissaA),
        .alignedMantissaB (alignedMantissaB),
        .guardBit         (alignGuard),
        .roundBit         (alignRound),
        .stickyBit        (alignSticky),
        .rawSum           (rawSum),
        .sumSign          (sumSign),
        .sumSticky        (sumSticky)
    );

    // Payload only moves with a valid pair
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            s1Exponent <= alignExponent;
            s1RawSum <= rawSum;
            s1Sign <= sumSign;
            s1Sticky <= sumSticky;
            s1Special <= alignSpecial;
            s1SpecialWord <= alignSpecialWord;
        end
    end

    fpNormalize i_normalize
    (
        .rawSum       (s1RawSum),
        .sumSticky    (s1Sticky),
        .exponentIn   (s1Exponent),
        .normMantissa (normMantissa),
        .normExponent (normExponent),
        .guardBit     (normGuard),
        .roundBit     (normRound),
        .stickyBit    (normSticky),
        .isZero       (sumIsZero)
    );

    fpRound i_round
    (
        .sign         (s1Sign),
        .normMantissa (normMantissa),
        .normExponent (normExponent),
        .guardBit     (normGuard),
        .roundBit     (normRound),
        .stickyBit    (normSticky),
        .isZero       (sumIsZero),
        .special      (s1Special),
        .specialWord  (s1SpecialWord),
        .roundedWord  (roundedWord)
    );

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            s1Valid <= 1'b0;
            outValid <= 1'b0;
            result <= '0;
        end
        else
        begin
            s1Valid <= inValid;
            outValid <= s1Valid;                          // Two cycles after inValid
            if (s1Valid)
                result <= roundedWord;
        end
    end

endmodule

/* verification/fpAdderVectors.svh */
// Test vectors for the binary32 adder with operand pairs, expected sums and test names

// Columns are the test name, operand A, operand B and the expected sum
task automatic loadVectors();
    addVector("1.0 + 1.0",               32'h3F800000, 32'h3F800000, 32'h40000000);
    addVector("1.5 + 2.5",               32'h3FC00000, 32'h40200000, 32'h40800000);
    addVector("1.0 + 2.0",               32'h3F800000, 32'h40000000, 32'h40400000);
    addVector("1.0 + 2^-20",             32'h3F800000, 32'h35800000, 32'h3F800008);
    addVector("2^23 + 1.0",              32'h4B000000, 32'h3F800000, 32'h4B000001);
    addVector("tie rounds down to even", 32'h3F800000, 32'h33800000, 32'h3F800000);
    addVector("tie rounds up to even",   32'h3F800001, 32'h33800000, 32'h3F800002);
    addVector("above half rounds up",    32'h3F800000, 32'h33C00000, 32'h3F800001);
    addVector("below half truncates",    32'h3F800000, 32'h33000000, 32'h3F800000);
    addVector("shift past 26 places",    32'h3F800000, 32'h30800000, 32'h3F800000);
    addVector("sum carries to 2.0",      32'h3FFFFFFF, 32'h34000000, 32'h40000000);
    addVector("rounding carries out",    32'h3FFFFFFF, 32'h33800000, 32'h40000000);
    addVector("1.0000001 - 1.0",         32'h3F800001, 32'hBF800000, 32'h34000000);
    addVector("exact cancellation",      32'h3F800000, 32'hBF800000, 32'h00000000);
    addVector("negative cancellation",   32'hBF800000, 32'h3F800000, 32'h00000000);
    addVector("larger negative wins",    32'h3F800000, 32'hC0000000, 32'hBF800000);
    addVector("larger positive wins",    32'hBFC00000, 32'h40800000, 32'h40200000);
    addVector("borrow tie to even",      32'h3F800000, 32'hB3000000, 32'h3F800000);
    addVector("borrow tie below one",    32'h3F800000, 32'hB3C00000, 32'h3F7FFFFE);
    addVector("3.0 - 1.0",               32'h40400000, 32'hBF800000, 32'h40000000);
    addVector("-1.0 + -2.0",             32'hBF800000, 32'hC0000000, 32'hC0400000);
    addVector("NaN in A",                32'h7F800001, 32'h3F800000, 32'h7FC00000);
    addVector("NaN in B",                32'h3F800000, 32'hFFC12345, 32'h7FC00000);
    addVector("inf minus inf",           32'h7F800000, 32'hFF800000, 32'h7FC00000);
    addVector("inf plus inf",            32'h7F800000, 32'h7F800000, 32'h7F800000);
    addVector("inf plus finite",         32'h7F800000, 32'h3F800000, 32'h7F800000);
    addVector("finite plus -inf",        32'h40000000, 32'hFF800000, 32'hFF800000);
    addVector("zero plus value",         32'h00000000, 32'h3FC00000, 32'h3FC00000);
    addVector("value plus -zero",        32'h40200000, 32'h80000000, 32'h40200000);
    addVector("-zero plus -zero",        32'h80000000, 32'h80000000, 32'h80000000);
    addVector("subnormal plus one",      32'h00400000, 32'h3F800000, 32'h3F800000);
    addVector("subnormal pair",          32'h00000001, 32'h00000001, 32'h00000000);
    addVector("opposite subnormals",     32'h80400000, 32'h00400000, 32'h00000000);
    addVector("overflow to +inf",        32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000);
    addVector("overflow to -inf",        32'hFF7FFFFF, 32'hFF7FFFFF, 32'hFF800000);
    addVector("underflow to +0",         32'h00800001, 32'h80800000, 32'h00000000);
    addVector("underflow to -0",         32'h80800001, 32'h00800000, 32'h80000000);
    addVector("smallest normals",        32'h00800000, 32'h00800000, 32'h01000000);
endtask

/* verification/fpAdderTb.sv */
`timescale 1ns/100ps
// Testbench for the pipelined binary32 adder, table driven with in-order result checking
module fpAdderTb;

    logic clk;
    logic rstN;
    logic inValid;
    fpPkg::fpWord_t operandA;
    fpPkg::fpWord_t operandB;
    logic outValid;
    fpPkg::fpWord_t result;

    // Vector table
    string rowName[$];
    logic [31:0] rowOperandA[$];
    logic [31:0] rowOperandB[$];
    logic [31:0] rowExpected[$];

    // Results still in flight
    string expectedNames[$];
    logic [31:0] expectedWords[$];
    int issueEdges[$];

    int cycleCount = 0;
    int errorCount = 0;
    int testCount = 0;
    int errorsAtStart;
    int drainCycles;
    int issueEdge;
    logic drivingDone;
    string pendingName;
    logic [31:0] pendingWord;

    fpAdder i_dut
    (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .outValid (outValid),
        .result   (result)
    );

    task automatic addVector(input string name, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] sum);
        rowName.push_back(name);
        rowOperandA.push_back(a);
        rowOperandB.push_back(b);
        rowExpected.push_back(sum);
    endtask

    `include "fpAdderVectors.svh"

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore)
            $display("Test %0d %s: ok", testCount, name);
        else
            $display("Test %0d %s: failed", testCount, name);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                            // 4 ns period
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    // Table is filled at time zero, so the limit is known one step later
    initial
    begin
        #1;
        #((rowExpected.size() + 20) * 4);
        $display("Timeout with %0d results never delivered", expectedWords.size());
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        rstN = 1'b0;
        inValid = 1'b0;
        operandA = '0;
        operandB = '0;
        drivingDone = 1'b0;
        drainCycles = 0;
        loadVectors();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        errorsAtStart = errorCount;
        checkValue("outValid after reset", 32'd0, {31'd0, outValid});
        checkValue("result after reset", 32'd0, result.bits);
        testCount++;
        reportTest("reset state", errorsAtStart);

        fork
            begin
                // One pair per cycle, back to back
                for (int i = 0; i < rowExpected.size(); i++)
                begin
                    @(negedge clk);
                    operandA.bits = rowOperandA[i];
                    operandB.bits = rowOperandB[i];
                    inValid = 1'b1;
                    expectedNames.push_back(rowName[i]);
                    expectedWords.push_back(rowExpected[i]);
                    issueEdges.push_back(cycleCount);         // Last edge before the pair is driven
                end
                @(negedge clk);
                inValid = 1'b0;
                operandA = '0;
                operandB = '0;
                drivingDone = 1'b1;
            end
            begin
                // Keeps watching a few idle cycles for stray strobes
                while (drainCycles < 4)
                begin
                    @(negedge clk);
                    if (outValid)
                    begin
                        if (expectedWords.size() == 0)
                        begin
                            errorCount++;
                            $display("Result %h arrived with no test waiting for it",
                                     result.bits);
                        end
                        else
                        begin
                            pendingName = expectedNames.pop_front();
                            pendingWord = expectedWords.pop_front();
                            issueEdge = issueEdges.pop_front();
                            errorsAtStart = errorCount;
                            checkValue(pendingName, pendingWord, result.bits);
                            checkValue({pendingName, " latency"}, 32'd2,
                                       cycleCount - issueEdge);
                            testCount++;
                            reportTest(pendingName, errorsAtStart);
                        end
                    end
                    if (drivingDone && (expectedWords.size() == 0))
                        drainCycles++;
                end
            end
        join

        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verification
logic/fpPkg.sv
logic/fpAlign.sv
logic/fpMantissaAdd.sv
logic/fpNormalize.sv
logic/fpRound.sv
logic/fpAdder.sv
verification/fpAdderTb.sv

/* run.sh */
#!/bin/sh
# Builds the adder testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module fpAdderTb -o fpAdderSim
./obj_dir/fpAdderSim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
